// File: Makefile
# Verilator build and run for the host controller testbench
TOP = tb_hs_top

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f
	verilator --lint-only --top-module hs_top -f compile.f

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+.
hs_pkg.sv
hs_ring_if.sv
hs_port.sv
hs_outband_ring.sv
hs_host_if.sv
hs_top.sv
hs_sva.sv
tb_hs_top.sv

// File: hs_defines.svh
// Shared macros for the four-port host controller
// Port count, ring geometry, bus widths and host register map
`ifndef HS_DEFINES_SVH
`define HS_DEFINES_SVH

// Channel and ring geometry
`define HS_NUM_PORTS 4
`define HS_RING_DEPTH 16
`define HS_RING_AW 4

// Word widths
`define HS_TAG_W 8
`define HS_DATA_W 32
`define HS_ADDR_W 10

// Host register map, word addresses
`define HS_REG_CTRL 10'h000
`define HS_REG_CONS 10'h001
`define HS_REG_PROD 10'h002
// Ring window, 16 words, read only
`define HS_REG_RING 10'h010
// Port command/status, one word per port
`define HS_REG_PORT 10'h020

`endif

// File: hs_host_if.sv
// Host register slave on the DCR-style bus
// Ring control, consumer index, interrupt, port command strobes, read mux
`timescale 1ns/1ps
`include "hs_defines.svh"

module hs_host_if (
   input  logic                   sys_clk,
   input  logic                   reset,
   input  logic                   dcr_read,
   input  logic                   dcr_write,
   input  logic [`HS_ADDR_W-1:0]  dcr_abus,
   input  logic [`HS_DATA_W-1:0]  dcr_wdata,
   output logic [`HS_DATA_W-1:0]  dcr_rdata,
   output logic                   dcr_ack,
   output logic                   interrupt,
   output logic                   ring_enable,
   output logic [`HS_RING_AW-1:0] cons_index,
   input  logic [`HS_RING_AW-1:0] prod_index,
   output logic [`HS_RING_AW-1:0] rd_addr,
   input  logic [`HS_DATA_W-1:0]  rd_data,
   output logic [`HS_NUM_PORTS-1:0] cmd_load,
   output logic [`HS_TAG_W-1:0]   cmd_tag,
   input  logic [`HS_DATA_W-1:0]  port_status [`HS_NUM_PORTS]
);

   localparam int NP = `HS_NUM_PORTS;
   localparam int PW = $clog2(NP);
   localparam int AW = `HS_RING_AW;

   logic                  wr_en;
   logic                  rd_en;
   logic [`HS_ADDR_W-1:0] ring_off;
   logic [`HS_ADDR_W-1:0] port_off;
   logic                  ring_hit;
   logic                  port_hit;
   logic [`HS_DATA_W-1:0] rd_mux;

   // Accesses act on the edge that raises ack
   assign wr_en = dcr_write & ~dcr_ack;
   assign rd_en = dcr_read & ~dcr_ack;

   // Window decode by offset from each base
   assign ring_off = dcr_abus - `HS_REG_RING;
   assign port_off = dcr_abus - `HS_REG_PORT;
   assign ring_hit = ring_off < `HS_ADDR_W'(`HS_RING_DEPTH);
   assign port_hit = port_off < `HS_ADDR_W'(NP);
   assign rd_addr  = ring_off[AW-1:0];

   assign cmd_tag   = dcr_wdata[`HS_TAG_W-1:0];
   assign interrupt = (prod_index != cons_index); // Unconsumed entries

   // One-cycle strobe to the addressed port
   always_comb
   begin
      for (int i = 0; i < NP; i++)
         cmd_load[i] = wr_en & port_hit & (port_off[PW-1:0] == PW'(i));
   end

   always_comb
   begin
      rd_mux = '0;
      if (ring_hit)
         rd_mux = rd_data;
      else if (port_hit)
         rd_mux = port_status[port_off[PW-1:0]];
      else
      begin
         case (dcr_abus)
            `HS_REG_CTRL: rd_mux[0]      = ring_enable;
            `HS_REG_CONS: rd_mux[AW-1:0] = cons_index;
            `HS_REG_PROD: rd_mux[AW-1:0] = prod_index;
            default:      rd_mux         = '0;  // Unmapped reads as zero
         endcase
      end
   end

   always_ff @(posedge sys_clk)
   begin
      if (reset)
      begin
         dcr_ack     <= 1'b0;
         ring_enable <= 1'b0;
         cons_index  <= '0;
      end
      else
      begin
         dcr_ack <= dcr_read | dcr_write;        // Follows the request
         if (wr_en && dcr_abus == `HS_REG_CTRL)
            ring_enable <= dcr_wdata[0];
         if (wr_en && dcr_abus == `HS_REG_CONS)
            cons_index <= dcr_wdata[AW-1:0];     // Host frees entries
      end
   end

   // Read data captured with ack, held while ack stays up
   always_ff @(posedge sys_clk)
   begin
      if (rd_en)
         dcr_rdata <= rd_mux;
   end

endmodule

// File: hs_outband_ring.sv
// Outband completion ring
// Round-robin arbiter over the port posters, entry memory, producer index
`timescale 1ns/1ps
`include "hs_defines.svh"

module hs_outband_ring (
   input  logic                   sys_clk,
   input  logic                   reset,
   input  logic                   ring_enable,
   input  logic [`HS_RING_AW-1:0] cons_index,
   input  logic [`HS_RING_AW-1:0] rd_addr,
   output logic [`HS_DATA_W-1:0]  rd_data,
   output logic [`HS_RING_AW-1:0] prod_index,
   hs_ring_if.ring                post [`HS_NUM_PORTS]
);
   import hs_pkg::*;

   localparam int NP = `HS_NUM_PORTS;
   localparam int PW = $clog2(NP);

   hs_ring_entry_u         mem [`HS_RING_DEPTH];
   hs_ring_entry_u         entry_vec [NP];
   logic [NP-1:0]          req_vec;
   logic [NP-1:0]          ack_q;
   logic [PW-1:0]          last_q;               // Last port granted
   logic [PW-1:0]          grant_idx;
   logic [PW-1:0]          cand;
   logic                   found;
   logic                   full;
   logic                   grant_ok;
   logic [`HS_RING_AW-1:0] prod_next;

   // Flatten the interface array
   for (genvar i = 0; i < NP; i++)
   begin : g_port
      assign req_vec[i]   = post[i].req;
      assign entry_vec[i] = post[i].entry;
      assign post[i].ack  = ack_q[i];
   end

   assign prod_next = prod_index + 1'b1;         // Wraps at depth
   assign full      = (prod_next == cons_index); // One slot kept empty

   // Search starts just after the last grant
   always_comb
   begin
      found     = 1'b0;
      grant_idx = last_q;
      cand      = last_q;
      for (int k = 1; k <= NP; k++)
      begin
         cand = last_q + PW'(k);
         if (!found && req_vec[cand])
         begin
            found     = 1'b1;
            grant_idx = cand;
         end
      end
   end

   // One handshake at a time, none while disabled or full
   assign grant_ok = found & ring_enable & ~full & (ack_q == '0);

   always_ff @(posedge sys_clk)
   begin
      if (reset)
      begin
         ack_q      <= '0;
         prod_index <= '0;
         last_q     <= PW'(NP - 1);              // Port 0 wins first
      end
      else
      begin
         for (int i = 0; i < NP; i++)
         begin
            if (ack_q[i] && !req_vec[i])
               ack_q[i] <= 1'b0;                 // Phase 4
         end
         if (grant_ok)
         begin
            ack_q[grant_idx] <= 1'b1;            // Same edge as the write
            prod_index       <= prod_next;
            last_q           <= grant_idx;
         end
      end
   end

   always_ff @(posedge sys_clk)
   begin
      if (grant_ok)
         mem[prod_index] <= entry_vec[grant_idx];
   end

   assign rd_data = mem[rd_addr];                // Host window read

endmodule

// File: hs_pkg.sv
// Ring entry kinds and error codes
// Packed union with the done and error views of one ring word
`include "hs_defines.svh"

package hs_pkg;

   typedef enum logic {
      HS_KIND_DONE  = 1'b0,                      // Command finished on a live link
      HS_KIND_ERROR = 1'b1                       // Command ended with an error
   } hs_kind_e;

   localparam logic [7:0] HS_ERR_LINK_DOWN = 8'h01;

   typedef struct packed {
      hs_kind_e              kind;               // Bit 31
      logic [1:0]            port;               // Posting channel
      logic [4:0]            rsvd;
      logic [`HS_TAG_W-1:0]  tag;                // Bits 23:16
      logic [15:0]           count;              // Completions so far
   } hs_done_s;

   typedef struct packed {
      hs_kind_e              kind;
      logic [1:0]            port;
      logic [4:0]            rsvd;
      logic [`HS_TAG_W-1:0]  tag;
      logic [7:0]            code;               // Bits 15:8
      logic [7:0]            zero;
   } hs_error_s;

   // Same 32 bits, decoded by kind
   typedef union packed {
      hs_done_s  done;
      hs_error_s err;
   } hs_ring_entry_u;

endpackage

// File: hs_port.sv
// Per-port command channel
// Holds the tag through the PHY phase, counts completions, posts ring entries
`timescale 1ns/1ps
`include "hs_defines.svh"

module hs_port #(
   parameter int port_id = 0
) (
   input  logic                  sys_clk,
   input  logic                  reset,
   input  logic                  cmd_load,
   input  logic [`HS_TAG_W-1:0]  cmd_tag,
   input  logic                  linkup,
   input  logic                  phy_done,
   output logic                  start_comm,
   output logic [`HS_DATA_W-1:0] port_status,
   hs_ring_if.poster             post
);
   import hs_pkg::*;

   localparam int CNT_W = 16;

   logic                 busy;                   // Command in flight
   logic                 ack_d;                  // Ack one cycle ago
   logic                 phy_fin;
   logic [`HS_TAG_W-1:0] tag_q;
   logic [CNT_W-1:0]     count;
   logic [CNT_W-1:0]     count_inc;
   hs_ring_entry_u       entry_d;

   assign phy_fin   = start_comm & phy_done;     // Start_comm implies busy
   assign count_inc = count + 1'b1;

   // Status word: busy on top, count at the bottom
   assign port_status = {busy, {(`HS_DATA_W-CNT_W-1){1'b0}}, count};

   // Entry built from the link state at the finishing edge
   always_comb
   begin
      entry_d = '0;
      if (linkup)
      begin
         entry_d.done.kind  = HS_KIND_DONE;
         entry_d.done.port  = 2'(port_id);
         entry_d.done.tag   = tag_q;
         entry_d.done.count = count_inc;         // Count after this command
      end
      else
      begin
         entry_d.err.kind = HS_KIND_ERROR;
         entry_d.err.port = 2'(port_id);
         entry_d.err.tag  = tag_q;
         entry_d.err.code = HS_ERR_LINK_DOWN;
      end
   end

   always_ff @(posedge sys_clk)
   begin
      if (reset)
      begin
         busy       <= 1'b0;
         start_comm <= 1'b0;
         post.req   <= 1'b0;
         ack_d      <= 1'b0;
         count      <= '0;
      end
      else
      begin
         ack_d <= post.ack;
         if (cmd_load && !busy)                  // Busy port ignores commands
         begin
            busy       <= 1'b1;
            start_comm <= 1'b1;
         end
         if (phy_fin)
         begin
            start_comm <= 1'b0;
            post.req   <= 1'b1;
         end
         if (post.req && post.ack)
            post.req <= 1'b0;                    // Phase 3
         if (ack_d && !post.ack)
         begin
            busy <= 1'b0;                        // Handshake closed
            if (post.entry.done.kind == HS_KIND_DONE)
               count <= count_inc;               // Link down keeps the count
         end
      end
   end

   always_ff @(posedge sys_clk)
   begin
      if (cmd_load && !busy)
         tag_q <= cmd_tag;
      if (phy_fin)
         post.entry <= entry_d;                  // Held until next command
   end

endmodule

// File: hs_ring_if.sv
// Posting link from one port channel to the outband ring
// Four-phase req/ack with the entry held stable under req
`timescale 1ns/1ps

interface hs_ring_if;
   import hs_pkg::*;

   logic           req;                          // Port wants a ring slot
   logic           ack;                          // Ring wrote the entry
   hs_ring_entry_u entry;                        // Port id lives inside

   modport poster (
      output req,
      output entry,
      input  ack
   );

   modport ring (
      input  req,
      input  entry,
      output ack
   );

endinterface

// File: hs_sva.sv
// Ring handshake and index assertions
// Bound into the outband ring
`timescale 1ns/1ps
`include "hs_defines.svh"

module hs_sva (
   input logic                       sys_clk,
   input logic                       reset,
   input logic                       ring_enable,
   input logic [`HS_RING_AW-1:0]     cons_index,
   input logic [`HS_RING_AW-1:0]     prod_index,
   input logic [`HS_NUM_PORTS-1:0]   req_vec,
   input logic [`HS_NUM_PORTS-1:0]   ack_q,
   input hs_pkg::hs_ring_entry_u     entry_vec [`HS_NUM_PORTS]
);

   localparam int AW = `HS_RING_AW;

   for (genvar i = 0; i < `HS_NUM_PORTS; i++)
   begin : g_chk
      // Entry frozen while req stays up
      a_entry_stable : assert property (@(posedge sys_clk) disable iff (reset)
         req_vec[i] |=> (!req_vec[i] || $stable(entry_vec[i])))
         else $error("entry of port %0d changed under req", i);

      // No ack without a request behind it
      a_ack_needs_req : assert property (@(posedge sys_clk) disable iff (reset)
         (!req_vec[i] && !ack_q[i]) |=> !ack_q[i])
         else $error("ack of port %0d rose without req", i);
   end

   a_no_grant_disabled : assert property (@(posedge sys_clk) disable iff (reset)
      (!ring_enable && ack_q == '0) |=> ack_q == '0)
      else $error("grant while ring disabled");

   // Full ring holds the producer
   a_full_holds_prod : assert property (@(posedge sys_clk) disable iff (reset)
      (AW'(prod_index + 1'b1) == cons_index) |=> $stable(prod_index))
      else $error("producer index advanced on a full ring");

endmodule

bind hs_outband_ring hs_sva u_sva (.*);

// File: hs_top.sv
// Host controller top level
// Four port channels, outband ring and host register slave
`timescale 1ns/1ps
`include "hs_defines.svh"

module hs_top (
   input  logic                     sys_clk,
   input  logic                     reset,
   input  logic                     dcr_read,
   input  logic                     dcr_write,
   input  logic [`HS_ADDR_W-1:0]    dcr_abus,
   input  logic [`HS_DATA_W-1:0]    dcr_wdata,
   output logic [`HS_DATA_W-1:0]    dcr_rdata,
   output logic                     dcr_ack,
   output logic                     interrupt,
   input  logic [`HS_NUM_PORTS-1:0] linkup,
   input  logic [`HS_NUM_PORTS-1:0] phy_done,
   output logic [`HS_NUM_PORTS-1:0] start_comm
);

   logic                     ring_enable;
   logic [`HS_RING_AW-1:0]   cons_index;
   logic [`HS_RING_AW-1:0]   prod_index;
   logic [`HS_RING_AW-1:0]   rd_addr;
   logic [`HS_DATA_W-1:0]    rd_data;
   logic [`HS_NUM_PORTS-1:0] cmd_load;
   logic [`HS_TAG_W-1:0]     cmd_tag;
   logic [`HS_DATA_W-1:0]    port_status [`HS_NUM_PORTS];

   hs_ring_if ring_bus [`HS_NUM_PORTS] ();       // One poster link per port

   for (genvar i = 0; i < `HS_NUM_PORTS; i++)
   begin : g_chan
      hs_port #(
         .port_id (i)
      ) u_port (
         .sys_clk     (sys_clk),
         .reset       (reset),
         .cmd_load    (cmd_load[i]),
         .cmd_tag     (cmd_tag),                 // Shared, strobe selects
         .linkup      (linkup[i]),
         .phy_done    (phy_done[i]),
         .start_comm  (start_comm[i]),
         .port_status (port_status[i]),
         .post        (ring_bus[i])
      );
   end

   hs_outband_ring u_ring (
      .sys_clk     (sys_clk),
      .reset       (reset),
      .ring_enable (ring_enable),
      .cons_index  (cons_index),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .prod_index  (prod_index),
      .post        (ring_bus)
   );

   hs_host_if u_host (
      .sys_clk     (sys_clk),
      .reset       (reset),
      .dcr_read    (dcr_read),
      .dcr_write   (dcr_write),
      .dcr_abus    (dcr_abus),
      .dcr_wdata   (dcr_wdata),
      .dcr_rdata   (dcr_rdata),
      .dcr_ack     (dcr_ack),
      .interrupt   (interrupt),
      .ring_enable (ring_enable),
      .cons_index  (cons_index),
      .prod_index  (prod_index),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .cmd_load    (cmd_load),
      .cmd_tag     (cmd_tag),
      .port_status (port_status)
   );

endmodule

// File: hs_trace.txt
// op addr data expect, hex; 0 wr, 1 rd+check, 2 poll rd, 3 wait irq, 4 linkup
// 5 expected entry for port, 6 unordered ring rd, 7 idle, 8 check irq, f end
1 000 0 00000000
1 001 0 00000000
1 002 0 00000000
8 000 0 0
4 000 f 0
0 000 1 0
0 021 a5 0
3 000 1 0
1 010 0 20a50001
2 021 0 00000001
0 001 1 0
3 000 0 0
// port 2 link down
4 000 b 0
0 022 3c 0
3 000 1 0
1 011 0 c03c0100
2 022 0 00000000
0 001 2 0
3 000 0 0
// all four ports at once
4 000 f 0
5 000 0 00110001
5 001 0 20220002
5 002 0 40330001
5 003 0 60440001
0 020 11 0
0 021 22 0
0 022 33 0
0 023 44 0
2 002 0 00000006
6 012 0 0
6 013 0 0
6 014 0 0
6 015 0 0
0 001 6 0
3 000 0 0
// ring disabled
0 000 0 0
5 000 0 00550002
5 001 0 20660003
0 020 55 0
0 021 66 0
7 000 14 0
1 002 0 00000006
1 020 0 80000001
8 000 0 0
0 000 1 0
2 002 0 00000008
6 016 0 0
6 017 0 0
// consumer one past producer makes the ring full
0 001 9 0
0 022 77 0
7 000 14 0
1 002 0 00000008
0 001 8 0
2 002 0 00000009
1 018 0 40770002
0 001 9 0
3 000 0 0
2 022 0 00000002
f 000 0 0

// File: tb_hs_top.sv
// Trace-driven testbench for the host controller top level
// Clock, reset, PHY model, host bus tasks, check task and timeout
`timescale 1ns/1ps
`include "hs_defines.svh"

module tb_hs_top;
   import hs_pkg::*;

   localparam int MAX_LINES = 64;
   localparam int NP        = `HS_NUM_PORTS;
   localparam int PW        = $clog2(NP);

   logic                  sys_clk;
   logic                  reset;
   logic                  dcr_read;
   logic                  dcr_write;
   logic [`HS_ADDR_W-1:0] dcr_abus;
   logic [`HS_DATA_W-1:0] dcr_wdata;
   logic [`HS_DATA_W-1:0] dcr_rdata;
   logic                  dcr_ack;
   logic                  interrupt;
   logic [NP-1:0]         linkup;
   logic [NP-1:0]         phy_done;
   logic [NP-1:0]         start_comm;

   logic [31:0]   trace_mem [4*MAX_LINES];    // Four words per trace line
   logic [31:0]   exp_entry [NP];              // Expected word per port
   logic [NP-1:0] seen;                        // Ports already read back
   logic [NP-1:0] sc_prev;
   logic [3:0]    phy_wait [NP];
   integer        seed;
   int            n_lines;
   int            cycles;
   int            limit;                       // Zero until the trace is loaded

   hs_top uut (
      .sys_clk    (sys_clk),
      .reset      (reset),
      .dcr_read   (dcr_read),
      .dcr_write  (dcr_write),
      .dcr_abus   (dcr_abus),
      .dcr_wdata  (dcr_wdata),
      .dcr_rdata  (dcr_rdata),
      .dcr_ack    (dcr_ack),
      .interrupt  (interrupt),
      .linkup     (linkup),
      .phy_done   (phy_done),
      .start_comm (start_comm)
   );

   always #50 sys_clk = ~sys_clk;              // 100 ns period

   task automatic fail_stop(input string what);
      $display("%s", what);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected)
         fail_stop($sformatf("Fail %s: got %h expected %h", name, actual, expected));
   endtask

   always @(posedge sys_clk)
   begin
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit)
         fail_stop($sformatf("Timeout: run went past %0d cycles", limit));
   end

   // PHY answers each start_comm rise with one done pulse, 1 to 8 cycles later
   always @(negedge sys_clk)
   begin
      for (int p = 0; p < NP; p++)
      begin
         if (phy_done[p])                      // Port saw the pulse last edge
            check($sformatf("start_comm[%0d]", p), {31'b0, start_comm[p]}, 32'h0);
         phy_done[p] = 1'b0;
         if (start_comm[p] && !sc_prev[p])
            phy_wait[p] = 4'(($random(seed) & 7) + 1);
         else if (phy_wait[p] != 4'd0)
         begin
            phy_wait[p] = phy_wait[p] - 4'd1;
            if (phy_wait[p] == 4'd0)
               phy_done[p] = 1'b1;
         end
         sc_prev[p] = start_comm[p];
      end
   end

   task automatic wait_ack(input logic level);
      do
         @(negedge sys_clk);
      while (dcr_ack !== level);
   endtask

   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
      @(negedge sys_clk);
      dcr_abus  = addr[`HS_ADDR_W-1:0];
      dcr_wdata = data;
      dcr_write = 1'b1;
      wait_ack(1'b1);
      dcr_write = 1'b0;                        // Ack falls on the next edge
      wait_ack(1'b0);
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
      @(negedge sys_clk);
      dcr_abus = addr[`HS_ADDR_W-1:0];
      dcr_read = 1'b1;
      wait_ack(1'b1);
      data     = dcr_rdata;                    // Valid while ack is high
      dcr_read = 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic run_line(input logic [31:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] expv);
      logic [31:0]    rdata;
      hs_ring_entry_u word;
      case (op[3:0])
         4'h0: bus_write(addr, data);
         4'h1:
         begin
            bus_read(addr, rdata);
            check($sformatf("dcr_rdata[%h]", addr[`HS_ADDR_W-1:0]), rdata, expv);
         end
         4'h2:
         begin
            bus_read(addr, rdata);
            while (rdata !== expv)             // Bounded by the cycle limit
               bus_read(addr, rdata);
         end
         4'h3:
            while (interrupt !== data[0])
               @(negedge sys_clk);
         4'h4:
         begin
            @(negedge sys_clk);
            linkup = data[NP-1:0];
         end
         4'h5:
         begin
            exp_entry[addr[PW-1:0]] = expv;
            seen[addr[PW-1:0]]      = 1'b0;
         end
         4'h6:
         begin
            bus_read(addr, rdata);
            word = rdata;
            if (seen[word.done.port])
               fail_stop($sformatf("Port %0d posted twice in one round", word.done.port));
            seen[word.done.port] = 1'b1;
            check("dcr_rdata ring entry", rdata, exp_entry[word.done.port]);
         end
         4'h7: repeat (data) @(negedge sys_clk);
         4'h8: check("interrupt", {31'b0, interrupt}, {31'b0, data[0]});
         default: fail_stop($sformatf("Unknown trace operation %h", op));
      endcase
   endtask

   initial
   begin
      sys_clk   = 1'b0;
      reset     = 1'b1;
      dcr_read  = 1'b0;
      dcr_write = 1'b0;
      dcr_abus  = '0;
      dcr_wdata = '0;
      linkup    = '0;
      phy_done  = '0;
      sc_prev   = '0;
      seen      = '0;
      seed      = 32'hf6c7_26cd;
      cycles    = 0;
      limit     = 0;
      for (int p = 0; p < NP; p++)
         phy_wait[p] = 4'd0;
      $readmemh("hs_trace.txt", trace_mem);
      n_lines = 0;
      while (n_lines < MAX_LINES && trace_mem[4*n_lines] !== 32'hf)
         n_lines++;
      if (n_lines == MAX_LINES)
         fail_stop("Trace file has no end marker");
      limit = 50 * (n_lines + 1);              // Reset time rides on the extra line
      repeat (5) @(negedge sys_clk);
      reset = 1'b0;
      for (int i = 0; i < n_lines; i++)
         run_line(trace_mem[4*i], trace_mem[4*i+1], trace_mem[4*i+2], trace_mem[4*i+3]);
      @(negedge sys_clk);
      $display("All checks passed");
      $finish;
   end

endmodule
